/* src/exe_pkg.sv */
package exe_pkg;

    localparam int XLEN = 32;

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_nor,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_lui,
        op_mul_w,
        op_mulh_w,
        op_mulh_wu,
        op_div_w,
        op_mod_w,
        op_div_wu,
        op_mod_wu,
        op_ld_b,
        op_ld_bu,
        op_ld_h,
        op_ld_hu,
        op_ld_w,
        op_st_b,
        op_st_h,
        op_st_w
    } exe_op_e;

    // decoded operation from the decode side
    typedef struct packed {
        logic [7:0]      tag;
        exe_op_e         op;
        logic            src1_is_pc;
        logic            src2_is_imm;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rj_value;
        logic [XLEN-1:0] rkd_value;
        logic [XLEN-1:0] imm;
        logic [4:0]      dest;
    } exe_req_t;

    typedef struct packed {
        logic [7:0]      tag;
        logic [4:0]      dest;
        logic [XLEN-1:0] result;
        logic            is_load;
        logic            is_store;
        logic            ale;
    } exe_rsp_t;

    // size: 0 byte, 1 halfword, 2 word
    typedef struct packed {
        logic            wr;
        logic [1:0]      size;
        logic [3:0]      wstrb;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } sram_req_t;

endpackage

/* src/skid_buffer.sv */
`timescale 1ns/1ns

module skid_buffer #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    input  logic up_valid,
    output logic up_ready,
    input  T     up_data,
    output logic down_valid,
    input  logic down_ready,
    output T     down_data
);

    logic main_valid;
    logic full;
    logic up_fire;
    T     main_data;
    T     skid_data;

    // ready comes straight from the full flop
    assign up_ready   = !full;
    assign up_fire    = up_valid && !full;
    assign down_valid = main_valid;
    assign down_data  = main_data;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            main_valid <= 1'b0;
            full       <= 1'b0;
        end
        else if (!main_valid || down_ready)
        begin
            main_valid <= full || up_fire;
            full       <= 1'b0;
        end
        else if (up_fire)
        begin
            full <= 1'b1;
        end
    end

    // skid entry drains into main first
    always_ff @(posedge clk)
    begin
        if (!main_valid || down_ready)
        begin
            if (full)
                main_data <= skid_data;
            else if (up_fire)
                main_data <= up_data;
        end
        else if (up_fire)
        begin
            skid_data <= up_data;
        end
    end

endmodule

/* src/alu.sv */
`timescale 1ns/1ns

module alu
    import exe_pkg::*;
(
    input  exe_op_e         op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    output logic [XLEN-1:0] result
);

    logic [4:0]      shamt;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;

    assign shamt = src2[4:0];
    assign sum   = src1 + src2;
    assign diff  = src1 - src2;

    always_comb
    begin
        case (op)
            op_sub:  result = diff;
            op_slt:  result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            op_sltu: result = {{(XLEN-1){1'b0}}, src1 < src2};
            op_and:  result = src1 & src2;
            op_or:   result = src1 | src2;
            op_nor:  result = ~(src1 | src2);
            op_xor:  result = src1 ^ src2;
            op_sll:  result = src1 << shamt;
            op_srl:  result = src1 >> shamt;
            op_sra:  result = $unsigned($signed(src1) >>> shamt);
            op_lui:  result = src2;
            // add, and address generation for loads and stores
            default: result = sum;
        endcase
    end

endmodule

/* src/divider.sv */
`timescale 1ns/1ns

module divider
    import exe_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic            is_signed,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic            busy,
    output logic            done,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder
);

    logic [4:0]      count;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] den_q;
    logic            quo_neg;
    logic            rem_neg;
    logic            zero_div;
    logic            dividend_neg;
    logic            divisor_neg;
    logic [XLEN-1:0] dividend_mag;
    logic [XLEN-1:0] divisor_mag;
    logic [XLEN:0]   partial;
    logic [XLEN+1:0] trial;

    assign dividend_neg = is_signed && dividend[XLEN-1];
    assign divisor_neg  = is_signed && divisor[XLEN-1];
    assign dividend_mag = dividend_neg ? -dividend : dividend;
    assign divisor_mag  = divisor_neg ? -divisor : divisor;

    // one restoring step, top bit of trial is the borrow
    assign partial = {rem_q, quo_q[XLEN-1]};
    assign trial   = {1'b0, partial} - {2'b00, den_q};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start && !busy)
            begin
                busy  <= 1'b1;
                count <= '0;
            end
            else if (busy)
            begin
                count <= count + 5'd1;
                if (count == 5'd31)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start && !busy)
        begin
            rem_q    <= '0;
            quo_q    <= dividend_mag;
            den_q    <= divisor_mag;
            quo_neg  <= dividend_neg ^ divisor_neg;
            rem_neg  <= dividend_neg;
            zero_div <= (divisor == '0);
        end
        else if (busy)
        begin
            quo_q <= {quo_q[XLEN-2:0], !trial[XLEN+1]};
            if (!trial[XLEN+1])
                rem_q <= trial[XLEN-1:0];
            else
                rem_q <= partial[XLEN-1:0];
        end
    end

    // sign fix-up on the way out
    // most negative / -1 wraps back to the dividend on its own
    assign quotient  = zero_div ? '1 : (quo_neg ? -quo_q : quo_q);
    assign remainder = rem_neg ? -rem_q : rem_q;

endmodule

/* src/lsu_req.sv */
`timescale 1ns/1ns

module lsu_req
    import exe_pkg::*;
(
    input  exe_op_e         op,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] store_value,
    output logic [1:0]      size,
    output logic [3:0]      wstrb,
    output logic [XLEN-1:0] wdata,
    output logic            is_load,
    output logic            is_store,
    output logic            ale
);

    logic [3:0] lane_mask;

    assign is_load  = op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
    assign is_store = op inside {op_st_b, op_st_h, op_st_w};

    always_comb
    begin
        case (op)
            op_ld_b, op_ld_bu, op_st_b: size = 2'd0;
            op_ld_h, op_ld_hu, op_st_h: size = 2'd1;
            default:                    size = 2'd2;
        endcase
    end

    // byte lanes at the address offset
    always_comb
    begin
        case (size)
            2'd0:    lane_mask = 4'b0001 << addr[1:0];
            2'd1:    lane_mask = 4'b0011 << addr[1:0];
            default: lane_mask = 4'b1111;
        endcase
    end

    assign wstrb = is_store ? lane_mask : 4'b0000;

    always_comb
    begin
        case (size)
            2'd0:    wdata = {4{store_value[7:0]}};
            2'd1:    wdata = {2{store_value[15:0]}};
            default: wdata = store_value;
        endcase
    end

    assign ale = (is_load || is_store) &&
                 ((size == 2'd2 && addr[1:0] != 2'b00) || (size == 2'd1 && addr[0]));

endmodule

/* src/exe_stage.sv */
`timescale 1ns/1ns

module exe_stage
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      up_valid,
    output logic      up_ready,
    input  exe_req_t  up_req,
    output logic      down_valid,
    input  logic      down_ready,
    output exe_rsp_t  down_rsp,
    output logic      sram_valid,
    output sram_req_t sram_req,
    input  logic      sram_addr_ok
);

    exe_req_t          req_q;
    logic              es_valid;
    logic              ready_go;
    logic              up_fire;
    logic [XLEN-1:0]   src1;
    logic [XLEN-1:0]   src2;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   result;

    logic              is_mul;
    logic              is_div;
    logic              is_mem;
    logic [XLEN:0]     mul_src1;
    logic [XLEN:0]     mul_src2;
    logic [2*XLEN+1:0] product;
    logic [XLEN-1:0]   mul_result;

    logic              div_signed;
    logic              div_start;
    logic              div_issued;
    logic              div_done_q;
    logic              div_busy;
    logic              div_done;
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;
    logic [XLEN-1:0]   div_result;

    logic [1:0]        mem_size;
    logic [3:0]        mem_wstrb;
    logic [XLEN-1:0]   mem_wdata;
    logic              is_load;
    logic              is_store;
    logic              ale;

    assign up_fire = up_valid && up_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            es_valid <= 1'b0;
        else if (up_ready)
            es_valid <= up_valid;
    end

    always_ff @(posedge clk)
    begin
        if (up_fire)
            req_q <= up_req;
    end

    assign src1 = req_q.src1_is_pc ? req_q.pc : req_q.rj_value;
    assign src2 = req_q.src2_is_imm ? req_q.imm : req_q.rkd_value;

    alu alu_inst (
        .op     (req_q.op),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    // 33x33 signed product covers both mulh forms
    assign is_mul   = req_q.op inside {op_mul_w, op_mulh_w, op_mulh_wu};
    assign mul_src1 = {req_q.op == op_mulh_w && src1[XLEN-1], src1};
    assign mul_src2 = {req_q.op == op_mulh_w && src2[XLEN-1], src2};
    assign product  = $signed(mul_src1) * $signed(mul_src2);
    assign mul_result = (req_q.op == op_mul_w) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

    assign is_div     = req_q.op inside {op_div_w, op_mod_w, op_div_wu, op_mod_wu};
    assign div_signed = req_q.op inside {op_div_w, op_mod_w};
    assign div_start  = es_valid && is_div && !div_issued && !div_busy;

    // per-operation divider progress, cleared when the next op comes in
    always_ff @(posedge clk)
    begin
        if (reset || up_fire)
        begin
            div_issued <= 1'b0;
            div_done_q <= 1'b0;
        end
        else
        begin
            if (div_start)
                div_issued <= 1'b1;
            if (div_done)
                div_done_q <= 1'b1;
        end
    end

    divider divider_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (src1),
        .divisor   (src2),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign div_result = (req_q.op inside {op_div_w, op_div_wu}) ? quotient : remainder;

    lsu_req lsu_req_inst (
        .op          (req_q.op),
        .addr        (alu_result),
        .store_value (req_q.rkd_value),
        .size        (mem_size),
        .wstrb       (mem_wstrb),
        .wdata       (mem_wdata),
        .is_load     (is_load),
        .is_store    (is_store),
        .ale         (ale)
    );

    assign is_mem = is_load || is_store;

    // a load's result is its address
    assign result = is_mul ? mul_result : (is_div ? div_result : alu_result);

    always_comb
    begin
        if (is_div)
            ready_go = div_done || div_done_q;
        else if (is_mem && !ale)
            ready_go = sram_valid && sram_addr_ok;
        else
            ready_go = 1'b1;
    end

    // only ask the SRAM when the response has somewhere to go
    assign sram_valid = es_valid && is_mem && !ale && down_ready;
    assign sram_req   = '{wr: is_store, size: mem_size, wstrb: mem_wstrb,
                          addr: alu_result, wdata: mem_wdata};

    assign up_ready   = !es_valid || (ready_go && down_ready);
    assign down_valid = es_valid && ready_go;
    assign down_rsp   = '{tag: req_q.tag, dest: req_q.dest, result: result,
                          is_load: is_load, is_store: is_store, ale: ale};

endmodule

/* src/exe_top.sv */
`timescale 1ns/1ns

module exe_top
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    output logic      in_ready,
    input  exe_req_t  in_req,
    output logic      out_valid,
    input  logic      out_ready,
    output exe_rsp_t  out_rsp,
    output logic      sram_valid,
    output sram_req_t sram_req,
    input  logic      sram_addr_ok
);

    logic     stage_in_valid;
    logic     stage_in_ready;
    exe_req_t stage_in_req;
    logic     stage_out_valid;
    logic     stage_out_ready;
    exe_rsp_t stage_out_rsp;

    skid_buffer #(
        .T (exe_req_t)
    ) in_slice (
        .clk        (clk),
        .reset      (reset),
        .up_valid   (in_valid),
        .up_ready   (in_ready),
        .up_data    (in_req),
        .down_valid (stage_in_valid),
        .down_ready (stage_in_ready),
        .down_data  (stage_in_req)
    );

    exe_stage stage (
        .clk          (clk),
        .reset        (reset),
        .up_valid     (stage_in_valid),
        .up_ready     (stage_in_ready),
        .up_req       (stage_in_req),
        .down_valid   (stage_out_valid),
        .down_ready   (stage_out_ready),
        .down_rsp     (stage_out_rsp),
        .sram_valid   (sram_valid),
        .sram_req     (sram_req),
        .sram_addr_ok (sram_addr_ok)
    );

    skid_buffer #(
        .T (exe_rsp_t)
    ) out_slice (
        .clk        (clk),
        .reset      (reset),
        .up_valid   (stage_out_valid),
        .up_ready   (stage_out_ready),
        .up_data    (stage_out_rsp),
        .down_valid (out_valid),
        .down_ready (out_ready),
        .down_data  (out_rsp)
    );

endmodule

/* bench/exe_chk.sv */
`timescale 1ns/1ns

module exe_chk
    import exe_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      out_valid,
    input logic      out_ready,
    input exe_rsp_t  out_rsp,
    input logic      sram_valid,
    input logic      sram_addr_ok,
    input sram_req_t sram_req
);

    int fail_count = 0;

    // stalled response stays put
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_rsp))
    else
    begin
        $error("out_rsp or out_valid changed while out_ready was low");
        fail_count++;
    end

    // SRAM request waits for addr_ok unchanged
    assert property (@(posedge clk) disable iff (reset)
        sram_valid && !sram_addr_ok |=> sram_valid && $stable(sram_req))
    else
    begin
        $error("sram_req or sram_valid changed before sram_addr_ok");
        fail_count++;
    end

    assert property (@(posedge clk) $past(reset) |-> !out_valid && !sram_valid)
    else
    begin
        $error("out_valid or sram_valid high during reset");
        fail_count++;
    end

endmodule

/* bench/exe_scoreboard.sv */
`timescale 1ns/1ns

module exe_scoreboard
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  logic      in_ready,
    input  exe_req_t  in_req,
    input  logic      out_valid,
    input  logic      out_ready,
    input  exe_rsp_t  out_rsp,
    input  logic      sram_valid,
    input  logic      sram_addr_ok,
    input  sram_req_t sram_req,
    output int        mismatches,
    output int        protocol_errors,
    output int        outstanding
);

    exe_rsp_t  rsp_q[$];
    sram_req_t sram_q[$];
    int        mismatch_count = 0;
    int        protocol_count = 0;
    int        pending = 0;

    assign mismatches      = mismatch_count;
    assign protocol_errors = protocol_count;
    assign outstanding     = pending;

    // expected response and SRAM request, straight from the ISA rules
    function automatic exe_rsp_t reference_rsp(input exe_req_t r, output sram_req_t sr,
                                               output logic issues);
        exe_rsp_t    rsp;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic [63:0] prod;
        logic [1:0]  size;
        logic        ld;
        logic        st;
        logic        misaligned;
        int          sa;
        int          sb;
        a    = r.src1_is_pc ? r.pc : r.rj_value;
        b    = r.src2_is_imm ? r.imm : r.rkd_value;
        sa   = a;
        sb   = b;
        addr = a + b;
        ld   = r.op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
        st   = r.op inside {op_st_b, op_st_h, op_st_w};
        if (r.op inside {op_ld_b, op_ld_bu, op_st_b})
            size = 2'd0;
        else if (r.op inside {op_ld_h, op_ld_hu, op_st_h})
            size = 2'd1;
        else
            size = 2'd2;
        misaligned = (ld || st) && ((size == 2'd2 && addr[1:0] != 2'b00) ||
                                    (size == 2'd1 && addr[0]));
        case (r.op)
            op_add:     res = a + b;
            op_sub:     res = a - b;
            op_slt:     res = (sa < sb) ? 32'd1 : 32'd0;
            op_sltu:    res = (a < b) ? 32'd1 : 32'd0;
            op_and:     res = a & b;
            op_or:      res = a | b;
            op_nor:     res = ~(a | b);
            op_xor:     res = a ^ b;
            op_sll:     res = a << b[4:0];
            op_srl:     res = a >> b[4:0];
            op_sra:     res = sa >>> b[4:0];
            op_lui:     res = b;
            op_mul_w:
            begin
                prod = {32'b0, a} * {32'b0, b};
                res  = prod[31:0];
            end
            op_mulh_w:
            begin
                prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                res  = prod[63:32];
            end
            op_mulh_wu:
            begin
                prod = {32'b0, a} * {32'b0, b};
                res  = prod[63:32];
            end
            op_div_w, op_mod_w:
            begin
                if (b == 32'd0)
                    res = (r.op == op_div_w) ? 32'hffff_ffff : a;
                else if (a == 32'h8000_0000 && b == 32'hffff_ffff)
                    res = (r.op == op_div_w) ? a : 32'd0;
                else
                    res = (r.op == op_div_w) ? sa / sb : sa % sb;
            end
            op_div_wu, op_mod_wu:
            begin
                if (b == 32'd0)
                    res = (r.op == op_div_wu) ? 32'hffff_ffff : a;
                else
                    res = (r.op == op_div_wu) ? a / b : a % b;
            end
            // loads and stores report their address
            default:    res = addr;
        endcase
        rsp.tag      = r.tag;
        rsp.dest     = r.dest;
        rsp.result   = res;
        rsp.is_load  = ld;
        rsp.is_store = st;
        rsp.ale      = misaligned;
        sr.wr    = st;
        sr.size  = size;
        sr.addr  = addr;
        if (!st)
            sr.wstrb = 4'b0000;
        else if (size == 2'd0)
            sr.wstrb = 4'b0001 << addr[1:0];
        else if (size == 2'd1)
            sr.wstrb = 4'b0011 << addr[1:0];
        else
            sr.wstrb = 4'b1111;
        if (size == 2'd0)
            sr.wdata = {4{r.rkd_value[7:0]}};
        else if (size == 2'd1)
            sr.wdata = {2{r.rkd_value[15:0]}};
        else
            sr.wdata = r.rkd_value;
        issues = (ld || st) && !misaligned;
        return rsp;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    // sample mid-cycle, where every handshake signal has settled
    always @(negedge clk)
    begin
        exe_rsp_t  exp_rsp;
        sram_req_t exp_sram;
        logic      issues;
        if (!reset)
        begin
            if (in_valid && in_ready)
            begin
                exp_rsp = reference_rsp(in_req, exp_sram, issues);
                rsp_q.push_back(exp_rsp);
                if (issues)
                    sram_q.push_back(exp_sram);
            end
            if (sram_valid && sram_addr_ok)
            begin
                if (sram_q.size() == 0)
                begin
                    $display("SRAM request at %0t with no aligned memory operation pending",
                             $time);
                    protocol_count++;
                end
                else
                begin
                    exp_sram = sram_q.pop_front();
                    check_field("sram_req.wr", sram_req.wr, exp_sram.wr);
                    check_field("sram_req.size", sram_req.size, exp_sram.size);
                    check_field("sram_req.wstrb", sram_req.wstrb, exp_sram.wstrb);
                    check_field("sram_req.addr", sram_req.addr, exp_sram.addr);
                    if (exp_sram.wr)
                        check_field("sram_req.wdata", sram_req.wdata, exp_sram.wdata);
                end
            end
            if (out_valid && out_ready)
            begin
                if (rsp_q.size() == 0)
                begin
                    $display("response at %0t with no request outstanding", $time);
                    protocol_count++;
                end
                else
                begin
                    exp_rsp = rsp_q.pop_front();
                    check_field("out_rsp.tag", out_rsp.tag, exp_rsp.tag);
                    check_field("out_rsp.dest", out_rsp.dest, exp_rsp.dest);
                    check_field("out_rsp.result", out_rsp.result, exp_rsp.result);
                    check_field("out_rsp.is_load", out_rsp.is_load, exp_rsp.is_load);
                    check_field("out_rsp.is_store", out_rsp.is_store, exp_rsp.is_store);
                    check_field("out_rsp.ale", out_rsp.ale, exp_rsp.ale);
                end
            end
        end
        pending = rsp_q.size() + sram_q.size();
    end

endmodule

/* bench/exe_tb.sv */
`timescale 1ns/1ns

module exe_tb;
    import exe_pkg::*;

    localparam int num_ops    = 600;
    localparam int clk_period = 40;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    exe_req_t  in_req;
    logic      out_valid;
    logic      out_ready;
    exe_rsp_t  out_rsp;
    logic      sram_valid;
    sram_req_t sram_req;
    logic      sram_addr_ok;
    int        mismatches;
    int        protocol_errors;
    int        outstanding;

    logic [31:0] stim_state = 32'd45764;
    logic [31:0] bp_state   = 32'd45764 ^ 32'h9e37_79b9;

    exe_top exe_top_inst (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_req       (in_req),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_rsp      (out_rsp),
        .sram_valid   (sram_valid),
        .sram_req     (sram_req),
        .sram_addr_ok (sram_addr_ok)
    );

    exe_scoreboard scoreboard_inst (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_req          (in_req),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_rsp         (out_rsp),
        .sram_valid      (sram_valid),
        .sram_addr_ok    (sram_addr_ok),
        .sram_req        (sram_req),
        .mismatches      (mismatches),
        .protocol_errors (protocol_errors),
        .outstanding     (outstanding)
    );

    bind exe_top exe_chk chk_inst (
        .clk          (clk),
        .reset        (reset),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_rsp      (out_rsp),
        .sram_valid   (sram_valid),
        .sram_addr_ok (sram_addr_ok),
        .sram_req     (sram_req)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // separate streams so the two processes never share state
    function automatic logic [31:0] draw_stim();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    function automatic logic [31:0] draw_bp();
        bp_state = xorshift32(bp_state);
        return bp_state;
    endfunction

    // corner values turn up about a quarter of the time
    function automatic logic [31:0] pick_operand();
        logic [31:0] kind;
        logic [31:0] value;
        kind  = draw_stim();
        value = draw_stim();
        case (kind[3:0])
            4'd0:    return 32'h0000_0000;
            4'd1:    return 32'h8000_0000;
            4'd2:    return 32'hffff_ffff;
            4'd3:    return 32'h0000_0001;
            default: return value;
        endcase
    endfunction

    function automatic exe_req_t random_req(input logic [7:0] tag);
        exe_req_t    r;
        logic [31:0] sel;
        logic [4:0]  opc;
        sel           = draw_stim();
        opc           = 5'(sel % 27);
        r.tag         = tag;
        r.op          = exe_op_e'(opc);
        r.src1_is_pc  = sel[8];
        r.src2_is_imm = sel[9];
        r.dest        = sel[14:10];
        r.pc          = draw_stim();
        r.rj_value    = pick_operand();
        r.rkd_value   = pick_operand();
        r.imm         = pick_operand();
        return r;
    endfunction

    // zero divisor and most negative over -1 for every divide form
    function automatic exe_req_t divide_corner(input int k, input logic [7:0] tag);
        exe_req_t r;
        r = '0;
        r.tag  = tag;
        r.dest = 5'(k + 1);
        case (k >> 1)
            0:       r.op = op_div_w;
            1:       r.op = op_mod_w;
            2:       r.op = op_div_wu;
            default: r.op = op_mod_wu;
        endcase
        r.pc  = 32'h1c00_0000;
        r.imm = 32'h0000_0004;
        if (k % 2 == 1)
        begin
            r.rj_value  = 32'h8000_0000;
            r.rkd_value = 32'hffff_ffff;
        end
        else
        begin
            r.rj_value  = 32'hedcb_a988;
            r.rkd_value = 32'h0000_0000;
        end
        return r;
    endfunction

    // hold the request until in_ready is seen at a rising edge
    task automatic drive_op(input exe_req_t r);
        in_req   = r;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        exe_req_t    req;
        logic [31:0] gap;
        int          sent;
        int          errors;
        in_valid     = 1'b0;
        in_req       = '0;
        out_ready    = 1'b0;
        sram_addr_ok = 1'b0;
        reset        = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        sent  = 0;
        for (int k = 0; k < 8; k++)
        begin
            req = divide_corner(k, sent[7:0]);
            drive_op(req);
            sent++;
        end
        while (sent < num_ops)
        begin
            req = random_req(sent[7:0]);
            drive_op(req);
            sent++;
            gap = draw_stim();
            if (gap[0])
            begin
                repeat (gap[2:1])
                begin
                    @(posedge clk);
                    #2;
                end
            end
        end
        while (outstanding != 0)
            @(negedge clk);
        // a few idle cycles to catch stray handshakes
        repeat (10) @(posedge clk);
        errors = mismatches + protocol_errors + exe_top_inst.chk_inst.fail_count;
        $display("errors: %0d mismatches, %0d protocol, %0d assertion", mismatches,
                 protocol_errors, exe_top_inst.chk_inst.fail_count);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // random back-pressure on the response and SRAM sides
    initial
    begin
        logic [31:0] bp;
        @(negedge reset);
        forever
        begin
            @(posedge clk);
            #2;
            bp           = draw_bp();
            out_ready    = bp[3:0] > 4'd4;
            sram_addr_ok = bp[4];
        end
    end

    initial
    begin
        #(num_ops * 40 * clk_period);
        $display("timeout: %0d responses or SRAM requests still outstanding", outstanding);
        $display("tests failed");
        $finish;
    end

endmodule

/* project.f */
src/exe_pkg.sv
src/skid_buffer.sv
src/alu.sv
src/divider.sv
src/lsu_req.sv
src/exe_stage.sv
src/exe_top.sv
bench/exe_chk.sv
bench/exe_scoreboard.sv
bench/exe_tb.sv
